// ==== Bender.yml ====
package:
  name: credit_buf

sources:
  - logic/credit_buf_pkg.sv
  - logic/wrap_counter.sv
  - logic/credit_ingress.sv
  - logic/ring_store.sv
  - logic/credit_egress.sv
  - logic/credit_buf_top.sv
  - target: test
    files:
      - tb/credit_buf_assertions.sv
      - tb/credit_buf_tb.sv

// ==== list.f ====
logic/credit_buf_pkg.sv
logic/wrap_counter.sv
logic/credit_ingress.sv
logic/ring_store.sv
logic/credit_egress.sv
logic/credit_buf_top.sv
tb/credit_buf_assertions.sv
tb/credit_buf_tb.sv

// ==== logic/credit_buf_pkg.sv ====
//--------------------------------------------------------------------------
// Link constants and beat types shared by the credit-controlled buffer
// Modules import it inside their bodies and use scoped names in headers
//--------------------------------------------------------------------------

package credit_buf_pkg;

  //--------------------------------------------------------------------------
  // Sizes
  //--------------------------------------------------------------------------

  // Payload width of one beat
  localparam int DATA_W = 16;

  // Ring depth, which also sets the upstream credit pool
  localparam int BUF_DEPTH = 6;

  // Pointers index 0 to BUF_DEPTH-1
  localparam int PTR_W = 3;

  // Counts run 0 to BUF_DEPTH inclusive
  localparam int CNT_W = 3;

  // Beats the sender may push in one cycle
  localparam int LANES = 2;

  // Holds a per-cycle beat count from 0 to LANES
  localparam int LANE_CNT_W = $clog2(LANES + 1);

  // Credits the egress owns toward downstream after reset or flush
  localparam int DOWN_CREDITS = 4;

  //--------------------------------------------------------------------------
  // Types
  //--------------------------------------------------------------------------

  // One beat on the link, last marks the end of a packet
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } beat_t;

  // One upstream cycle; lane 0 is taken before lane 1 and either may be idle
  typedef struct packed {
    logic [LANES-1:0]  valid;
    beat_t [LANES-1:0] lane;
  } push_t;

endpackage

// ==== logic/credit_buf_top.sv ====
//--------------------------------------------------------------------------
// Credit-controlled elastic buffer for one point-to-point link
// Upstream pushes up to two beats against credits, downstream takes one
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module credit_buf_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  credit_buf_pkg::push_t push,
  output logic                  credit_return,
  output logic                  out_valid,
  output credit_buf_pkg::beat_t out_beat,
  input  logic                  down_credit,
  output logic                  overrun
);

  import credit_buf_pkg::*;

  // Write request from ingress to store
  logic [LANE_CNT_W-1:0] wr_count;
  beat_t [LANES-1:0]     wr_beats;
  // Head of the store and the pop handshake with egress
  beat_t                 rd_beat;
  logic [CNT_W-1:0]      occupancy;
  logic                  rd_pop;

  credit_ingress u_credit_ingress (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (flush),
    .push     (push),
    .occupancy(occupancy),
    .wr_count (wr_count),
    .wr_beats (wr_beats),
    .overrun  (overrun)
  );

  ring_store u_ring_store (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (flush),
    .wr_count (wr_count),
    .wr_beats (wr_beats),
    .rd_pop   (rd_pop),
    .rd_beat  (rd_beat),
    .occupancy(occupancy)
  );

  credit_egress u_credit_egress (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .rd_beat      (rd_beat),
    .occupancy    (occupancy),
    .down_credit  (down_credit),
    .rd_pop       (rd_pop),
    .out_valid    (out_valid),
    .out_beat     (out_beat),
    .credit_return(credit_return)
  );

endmodule

// ==== logic/credit_egress.sv ====
//--------------------------------------------------------------------------
// Downstream side of the buffer, pops the head while downstream credit lasts
// Each pop is registered to the output and returns one upstream credit
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module credit_egress (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             flush,
  input  credit_buf_pkg::beat_t            rd_beat,
  input  logic [credit_buf_pkg::CNT_W-1:0] occupancy,
  input  logic                             down_credit,
  output logic                             rd_pop,
  output logic                             out_valid,
  output credit_buf_pkg::beat_t            out_beat,
  output logic                             credit_return
);

  import credit_buf_pkg::*;

  logic [CNT_W-1:0] down_cnt;

  // Pop needs a stored beat and a downstream credit; nothing leaves in the
  // flush cycle since the contents are being discarded
  assign rd_pop = !flush && (occupancy != '0) && (down_cnt != '0);

  //--------------------------------------------------------------------------
  // Downstream credit
  //--------------------------------------------------------------------------

  // A pop spends one credit and a down_credit pulse brings one back; both can
  // land on the same edge and cancel out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      down_cnt <= CNT_W'(DOWN_CREDITS);
    end else if (flush) begin
      down_cnt <= CNT_W'(DOWN_CREDITS);
    end else begin
      down_cnt <= down_cnt - CNT_W'(rd_pop) + CNT_W'(down_credit);
    end
  end

  //--------------------------------------------------------------------------
  // Output stage
  //--------------------------------------------------------------------------

  // out_valid is high the cycle after the pop edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= rd_pop;
    end
  end

  // Payload only, loaded on a pop and left stale otherwise
  always_ff @(posedge clk) begin
    if (rd_pop) begin
      out_beat <= rd_beat;
    end
  end

  // One credit back upstream per pop, a single-cycle pulse after the pop edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_return <= 1'b0;
    end else begin
      credit_return <= rd_pop;
    end
  end

endmodule

// ==== logic/credit_ingress.sv ====
//--------------------------------------------------------------------------
// Upstream side of the buffer, turns a two-lane push into a compact write
// Also watches the sender's credit use and flags an overrun until flush
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module credit_ingress (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 flush,
  input  credit_buf_pkg::push_t                                push,
  input  logic [credit_buf_pkg::CNT_W-1:0]                     occupancy,
  output logic [credit_buf_pkg::LANE_CNT_W-1:0]                wr_count,
  output credit_buf_pkg::beat_t [credit_buf_pkg::LANES-1:0]    wr_beats,
  output logic                                                 overrun
);

  import credit_buf_pkg::*;

  logic [LANE_CNT_W-1:0] lane_count;
  logic [CNT_W:0]        fill_after;
  logic                  over_limit;

  // Number of valid lanes this cycle, 0 to LANES
  always_comb begin
    lane_count = '0;
    for (int i = 0; i < LANES; i++) begin
      lane_count = lane_count + LANE_CNT_W'(push.valid[i]);
    end
  end

  // Slot 0 takes the first valid lane, so a lane-1-only push lands in slot 0
  // and the store only ever fills slots from the bottom
  assign wr_beats[0] = push.valid[0] ? push.lane[0] : push.lane[1];
  assign wr_beats[1] = push.lane[1];

  // A push in the flush cycle is dropped before it reaches the store
  assign wr_count = flush ? '0 : lane_count;

  //--------------------------------------------------------------------------
  // Credit check
  //--------------------------------------------------------------------------

  // Returned credits trail pops by a cycle, so the sender never owns more than
  // BUF_DEPTH minus the current occupancy; going past that means it cheated
  assign fill_after = {1'b0, occupancy} + (CNT_W + 1)'(lane_count);
  assign over_limit = fill_after > (CNT_W + 1)'(BUF_DEPTH);

  // Sticky error flag, only a flush clears it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overrun <= 1'b0;
    end else if (flush) begin
      overrun <= 1'b0;
    end else if (over_limit) begin
      overrun <= 1'b1;
    end
  end

endmodule

// ==== logic/ring_store.sv ====
//--------------------------------------------------------------------------
// Six-entry ring taking up to two beats per cycle and giving one per pop
// Pointers and occupancy are wrapping counters, a flush reinits all three
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module ring_store (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              flush,
  input  logic [credit_buf_pkg::LANE_CNT_W-1:0]             wr_count,
  input  credit_buf_pkg::beat_t [credit_buf_pkg::LANES-1:0] wr_beats,
  input  logic                                              rd_pop,
  output credit_buf_pkg::beat_t                             rd_beat,
  output logic [credit_buf_pkg::CNT_W-1:0]                  occupancy
);

  import credit_buf_pkg::*;

  beat_t              mem [BUF_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   wr_ptr_succ;
  logic [PTR_W-1:0]   rd_ptr;
  logic signed [CNT_W:0] occ_net;
  logic [CNT_W-1:0]   occ_incr;
  logic               occ_valid;

  //--------------------------------------------------------------------------
  // Pointers
  //--------------------------------------------------------------------------

  // Write pointer advances by the number of beats written, wrapping at 5
  wrap_counter #(.MAX_VALUE(BUF_DEPTH - 1), .MAX_INCR(LANES)) u_wr_ptr (
    .clk          (clk),
    .rst_n        (rst_n),
    .reinit       (flush),
    .initial_value('0),
    .incr_valid   (wr_count != '0),
    .incr         (wr_count),
    .value        (wr_ptr),
    .value_next   ()
  );

  wrap_counter #(.MAX_VALUE(BUF_DEPTH - 1), .MAX_INCR(1)) u_rd_ptr (
    .clk          (clk),
    .rst_n        (rst_n),
    .reinit       (flush),
    .initial_value('0),
    .incr_valid   (rd_pop),
    .incr         (1'b1),
    .value        (rd_ptr),
    .value_next   ()
  );

  // Slot 1 goes one entry past slot 0, with the same wrap at 5
  assign wr_ptr_succ = (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;

  //--------------------------------------------------------------------------
  // Occupancy
  //--------------------------------------------------------------------------

  // Net change is -1 to +2; a pop with no write becomes +BUF_DEPTH, which is
  // -1 modulo BUF_DEPTH+1, so the up-only counter also steps down
  assign occ_net   = (CNT_W + 1)'(wr_count) - (CNT_W + 1)'(rd_pop);
  assign occ_incr  = occ_net[CNT_W] ? CNT_W'(BUF_DEPTH) : occ_net[CNT_W-1:0];
  assign occ_valid = (wr_count != '0) || rd_pop;

  wrap_counter #(.MAX_VALUE(BUF_DEPTH), .MAX_INCR(BUF_DEPTH)) u_occupancy (
    .clk          (clk),
    .rst_n        (rst_n),
    .reinit       (flush),
    .initial_value('0),
    .incr_valid   (occ_valid),
    .incr         (occ_incr),
    .value        (occupancy),
    .value_next   ()
  );

  //--------------------------------------------------------------------------
  // Storage
  //--------------------------------------------------------------------------

  // The ingress has already checked credits, so writes are never refused
  always_ff @(posedge clk) begin
    if (wr_count != '0) begin
      mem[wr_ptr] <= wr_beats[0];
    end
    if (wr_count == LANE_CNT_W'(LANES)) begin
      mem[wr_ptr_succ] <= wr_beats[1];
    end
  end

  // Head entry is always presented, valid whenever occupancy is nonzero
  assign rd_beat = mem[rd_ptr];

endmodule

// ==== logic/wrap_counter.sv ====
//--------------------------------------------------------------------------
// Counter with a variable increment that wraps at MAX_VALUE, any modulus
// Used for ring pointers and counts; reinit reloads the initial value
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module wrap_counter #(
  parameter int MAX_VALUE = 1,
  parameter int MAX_INCR = 1,
  localparam int VALUE_W = $clog2(MAX_VALUE + 1),
  localparam int INCR_W = $clog2(MAX_INCR + 1)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               reinit,
  input  logic [VALUE_W-1:0] initial_value,
  input  logic               incr_valid,
  input  logic [INCR_W-1:0]  incr,
  output logic [VALUE_W-1:0] value,
  output logic [VALUE_W-1:0] value_next
);

  localparam int MODULUS = MAX_VALUE + 1;
  localparam bit IS_POW2 = (MODULUS & (MODULUS - 1)) == 0;
  // Wide enough for the largest unwrapped sum, MAX_VALUE plus MAX_INCR
  localparam int SUM_W = $clog2(MAX_VALUE + MAX_INCR + 1);

  logic [VALUE_W-1:0] base;
  logic [SUM_W-1:0]   sum;
  logic [VALUE_W-1:0] sum_wrapped;

  // A reinit restarts from the initial value, and an increment in the same
  // cycle is applied on top of it rather than on the old value
  assign base = reinit ? initial_value : value;
  assign sum  = SUM_W'(base) + SUM_W'(incr);

  if (IS_POW2) begin : gen_pow2
    // The modulus matches the register width, so dropping the carry wraps
    assign sum_wrapped = sum[VALUE_W-1:0];
  end else begin : gen_non_pow2
    logic [SUM_W-1:0] sum_minus_mod;

    // Both operands stay within range, so one subtraction is always enough
    assign sum_minus_mod = sum - SUM_W'(MODULUS);
    assign sum_wrapped = (sum > SUM_W'(MAX_VALUE)) ? sum_minus_mod[VALUE_W-1:0]
                                                   : sum[VALUE_W-1:0];
  end

  // Lookahead of the register, held at the base when nothing is added
  assign value_next = incr_valid ? sum_wrapped : base;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      value <= initial_value;
    end else if (incr_valid || reinit) begin
      value <= value_next;
    end
  end

endmodule

// ==== tb/credit_buf_assertions.sv ====
//--------------------------------------------------------------------------
// Concurrent checks on the credit buffer, bound into every credit_buf_top
// Covers the occupancy bound, downstream credit use and credit return timing
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module credit_buf_assertions (
  input logic                             clk,
  input logic                             rst_n,
  input logic                             flush,
  input credit_buf_pkg::push_t            push,
  input logic                             down_credit,
  input logic [credit_buf_pkg::CNT_W-1:0] occupancy,
  input logic                             rd_pop,
  input logic                             out_valid,
  input logic                             credit_return,
  input logic                             overrun
);

  import credit_buf_pkg::*;

  logic [CNT_W+1:0] push_beats;
  logic [CNT_W+1:0] fill;
  logic [CNT_W:0]   link_credit;

  // Beats offered by the sender this cycle, whatever the lane pattern
  always_comb begin
    push_beats = '0;
    for (int i = 0; i < LANES; i++) begin
      push_beats = push_beats + (CNT_W + 2)'(push.valid[i]);
    end
  end

  // Fill level seen from the ports, as beats accepted minus beats popped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill <= '0;
    end else if (flush) begin
      fill <= '0;
    end else begin
      fill <= fill + push_beats - (CNT_W + 2)'(rd_pop);
    end
  end

  // Downstream credit as the receiver counts it, spent by each output beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      link_credit <= (CNT_W + 1)'(DOWN_CREDITS);
    end else if (flush) begin
      link_credit <= (CNT_W + 1)'(DOWN_CREDITS);
    end else begin
      link_credit <= link_credit - (CNT_W + 1)'(out_valid) + (CNT_W + 1)'(down_credit);
    end
  end

  // The ring never holds more beats than it has entries and its count tracks
  // the ports; after an overrun the contents are undefined until a flush
  occupancy_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    !overrun |-> ((fill <= (CNT_W + 2)'(BUF_DEPTH)) && (occupancy == CNT_W'(fill)))
  ) else $error("occupancy %0d, expected %0d within the ring depth", occupancy, fill);

  // Every output beat is covered by a credit the receiver handed out
  valid_had_credit: assert property (
    @(posedge clk) disable iff (!rst_n) out_valid |-> (link_credit != '0)
  ) else $error("out_valid without downstream credit");

  // One upstream credit per pop, exactly one cycle later
  return_follows_pop: assert property (
    @(posedge clk) disable iff (!rst_n) credit_return == $past(rd_pop)
  ) else $error("credit_return does not follow rd_pop by one cycle");

endmodule

bind credit_buf_top credit_buf_assertions u_credit_buf_assertions (
  .clk          (clk),
  .rst_n        (rst_n),
  .flush        (flush),
  .push         (push),
  .down_credit  (down_credit),
  .occupancy    (occupancy),
  .rd_pop       (rd_pop),
  .out_valid    (out_valid),
  .credit_return(credit_return),
  .overrun      (overrun)
);

// ==== tb/credit_buf_tb.sv ====
//--------------------------------------------------------------------------
// Directed testbench for the credit buffer with a reference queue of beats
// Inputs change on the falling edge, where registered outputs are sampled
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module credit_buf_tb;

  import credit_buf_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_TESTS = 6;
  localparam int CYCLES_PER_TEST = 200;

  logic  clk;
  logic  rst_n;
  logic  flush;
  push_t push;
  logic  credit_return;
  logic  out_valid;
  beat_t out_beat;
  logic  down_credit;
  logic  overrun;

  // Sender model with owned credits, beats in flight and pending downstream credit
  beat_t  ref_q [$];
  int     credits;
  int     beats_seen;
  int     returns_seen;
  int     down_pulses;
  bit     auto_return;
  push_t  push_req;
  logic   flush_req;
  logic   s_out_valid;
  logic   s_overrun;
  int     errors;
  int     checks;
  integer seed;

  credit_buf_top u_credit_buf_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .push         (push),
    .credit_return(credit_return),
    .out_valid    (out_valid),
    .out_beat     (out_beat),
    .down_credit  (down_credit),
    .overrun      (overrun)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // Budget covers every test at its worst case
  initial begin
    #(CYCLES_PER_TEST * NUM_TESTS * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles",
             CYCLES_PER_TEST * NUM_TESTS);
    $display("STATUS: FAIL");
    $finish;
  end

  //--------------------------------------------------------------------------
  // Compare tasks
  //--------------------------------------------------------------------------

  task automatic check_beat(input string name, input beat_t got, input beat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic expect_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report(input string name, input int errs_at_start);
    $display("test %s %s", name, (errors == errs_at_start) ? "passed" : "FAILED");
  endtask

  //--------------------------------------------------------------------------
  // Cycle and sender helpers
  //--------------------------------------------------------------------------

  // One clock that samples the outputs of the last edge, then drives the next inputs
  task automatic step();
    beat_t expected;
    @(negedge clk);
    s_out_valid = out_valid;
    s_overrun   = overrun;
    if (out_valid) begin
      if (ref_q.size() == 0) begin
        errors++;
        $display("A beat came out while no beat was expected");
      end else begin
        expected = ref_q.pop_front();
        check_beat("out_beat", out_beat, expected);
      end
      beats_seen++;
      // Downstream hands its credit back on the next edge
      if (auto_return) down_pulses++;
    end
    if (credit_return) begin
      credits++;
      returns_seen++;
    end
    // Both come from the same pop, one cycle later
    check_bit("credit_return", credit_return, out_valid);
    if (credits > BUF_DEPTH) begin
      errors++;
      $display("The sender was given more credits than the ring has entries");
    end
    push        = push_req;
    flush       = flush_req;
    down_credit = (down_pulses > 0);
    if (down_pulses > 0) down_pulses--;
    push_req  = '0;
    flush_req = 1'b0;
  endtask

  // Random payload in every lane, idle lanes too, so compaction is visible
  task automatic random_push(input logic [1:0] valid, output push_t p);
    logic [31:0] r;
    p.valid = valid;
    for (int i = 0; i < LANES; i++) begin
      r = $random(seed);
      p.lane[i].data = r[DATA_W-1:0];
      p.lane[i].last = r[DATA_W];
    end
  endtask

  // Legal push that waits for enough credit; lane 0 is expected first
  task automatic send(input logic [1:0] valid);
    push_t p;
    int    n;
    n = int'(valid[0]) + int'(valid[1]);
    while (credits < n) step();
    random_push(valid, p);
    for (int i = 0; i < LANES; i++) begin
      if (valid[i]) ref_q.push_back(p.lane[i]);
    end
    credits -= n;
    push_req = p;
    step();
  endtask

  // Runs until every expected beat is out and downstream credit is settled
  task automatic drain();
    while (ref_q.size() != 0 || down_pulses != 0) step();
    repeat (3) step();
  endtask

  //--------------------------------------------------------------------------
  // Tests
  //--------------------------------------------------------------------------

  task automatic single_beat();
    int e0;
    int r0;
    e0 = errors;
    r0 = returns_seen;
    send(2'b01);
    // Out two edges after the push edge, for exactly one cycle
    step();
    check_bit("out_valid", s_out_valid, 1'b0);
    step();
    check_bit("out_valid", s_out_valid, 1'b1);
    step();
    check_bit("out_valid", s_out_valid, 1'b0);
    drain();
    expect_count("credit_return pulses", returns_seen - r0, 1);
    report("single beat", e0);
  endtask

  task automatic lane_order_wrap();
    int e0;
    int b0;
    int sent;
    e0 = errors;
    b0 = beats_seen;
    sent = 0;
    // Cycles through idle, lane 0, lane 1 only and both, wrapping pointers often
    for (int i = 0; i < 28; i++) begin
      send(2'(i % 4));
      sent += (i % 4 == 3) ? 2 : ((i % 4 == 0) ? 0 : 1);
    end
    drain();
    expect_count("beats out", beats_seen - b0, sent);
    report("lane order and wrap", e0);
  endtask

  // Leaves the egress with zero downstream credit
  task automatic downstream_stall();
    int e0;
    int b0;
    int prev;
    e0 = errors;
    b0 = beats_seen;
    auto_return = 1'b0;
    repeat (3) send(2'b11);
    repeat (12) step();
    expect_count("beats out", beats_seen - b0, DOWN_CREDITS);
    check_bit("out_valid", s_out_valid, 1'b0);
    for (int k = 1; k <= 2; k++) begin
      prev = beats_seen;
      down_pulses = 1;
      while (beats_seen == prev) step();
      repeat (6) step();
      expect_count("beats out", beats_seen - b0, DOWN_CREDITS + k);
      check_bit("out_valid", s_out_valid, 1'b0);
    end
    report("downstream stall", e0);
  endtask

  task automatic credit_conservation();
    int e0;
    int b0;
    int r0;
    e0 = errors;
    b0 = beats_seen;
    expect_count("upstream credits", credits, BUF_DEPTH);
    r0 = returns_seen;
    repeat (3) send(2'b11);
    repeat (10) step();
    expect_count("beats out", beats_seen - b0, 0);
    expect_count("upstream credits", credits, 0);
    // Pay back the stalled credit, then downstream keeps up again
    auto_return = 1'b1;
    down_pulses = DOWN_CREDITS;
    drain();
    expect_count("credit_return pulses", returns_seen - r0, BUF_DEPTH);
    expect_count("upstream credits", credits, BUF_DEPTH);
    report("credit conservation", e0);
  endtask

  task automatic overrun_flag();
    int    e0;
    push_t p;
    e0 = errors;
    auto_return = 1'b0;
    // Four beats leave on the egress credit and six stay in a full ring
    repeat (5) send(2'b11);
    repeat (8) step();
    expect_count("upstream credits", credits, 0);
    check_bit("overrun", s_overrun, 1'b0);
    // Two beats pushed without credit and left out of the reference queue,
    // so the ring count ends up nonzero and only a flush can empty it
    random_push(2'b11, p);
    push_req = p;
    step();
    repeat (5) begin
      step();
      check_bit("overrun", s_overrun, 1'b1);
    end
    report("overrun", e0);
  endtask

  task automatic flush_recovery();
    int    e0;
    int    b0;
    int    r0;
    push_t p;
    e0 = errors;
    // A push in the flush cycle must be dropped
    random_push(2'b01, p);
    push_req  = p;
    flush_req = 1'b1;
    step();
    ref_q.delete();
    credits = BUF_DEPTH;
    down_pulses = 0;
    auto_return = 1'b1;
    step();
    check_bit("overrun", s_overrun, 1'b0);
    repeat (6) begin
      step();
      check_bit("out_valid", s_out_valid, 1'b0);
    end
    b0 = beats_seen;
    r0 = returns_seen;
    repeat (3) send(2'b11);
    drain();
    expect_count("beats out", beats_seen - b0, BUF_DEPTH);
    expect_count("credit_return pulses", returns_seen - r0, BUF_DEPTH);
    report("flush", e0);
  endtask

  //--------------------------------------------------------------------------
  // Sequence
  //--------------------------------------------------------------------------

  initial begin
    seed         = 32'hd60c;
    rst_n        = 1'b0;
    flush        = 1'b0;
    push         = '0;
    down_credit  = 1'b0;
    push_req     = '0;
    flush_req    = 1'b0;
    credits      = BUF_DEPTH;
    beats_seen   = 0;
    returns_seen = 0;
    down_pulses  = 0;
    auto_return  = 1'b1;
    errors       = 0;
    checks       = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("credit_return", credit_return, 1'b0);
    check_bit("overrun", overrun, 1'b0);
    single_beat();
    lane_order_wrap();
    downstream_stall();
    credit_conservation();
    overrun_flag();
    flush_recovery();
    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
